//--- common/lc3_ctrl_pkg.sv
package lc3_ctrl_pkg;

    // widths fixed by the instruction set
    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int STEP_W    = 3;
    localparam int NZP_W     = 3;

    // instruction field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int DR_MSB     = 11;
    localparam int DR_LSB     = 9;
    localparam int SR1_MSB    = 8;
    localparam int SR1_LSB    = 6;
    localparam int SR2_MSB    = 2;
    localparam int SR2_LSB    = 0;
    localparam int IMM_BIT    = 5;
    // branch mask shares the dr field
    localparam int NZP_MSB    = 11;
    localparam int NZP_LSB    = 9;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [STEP_W-1:0]    step_t;
    // n, z, p from msb down
    typedef logic [NZP_W-1:0]     nzp_t;

    typedef logic [1:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 2'b00;
    localparam alu_op_t ALU_AND  = 2'b01;
    localparam alu_op_t ALU_NOT  = 2'b10;
    localparam alu_op_t ALU_PASS = 2'b11;

    typedef logic [1:0] pc_sel_t;
    localparam pc_sel_t PC_FROM_BUS   = 2'b00;
    localparam pc_sel_t PC_FROM_ADDER = 2'b01;
    localparam pc_sel_t PC_INCR       = 2'b10;
    localparam pc_sel_t PC_HOLD       = 2'b11;

    typedef logic [1:0] addr2_sel_t;
    localparam addr2_sel_t ADDR2_OFF11 = 2'b00;
    localparam addr2_sel_t ADDR2_OFF9  = 2'b01;
    localparam addr2_sel_t ADDR2_OFF6  = 2'b10;
    localparam addr2_sel_t ADDR2_ZERO  = 2'b11;

    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LD   = 4'b0010,
        OP_ST   = 4'b0011,
        OP_JSR  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_RTI  = 4'b1000,
        OP_NOT  = 4'b1001,
        OP_LDI  = 4'b1010,
        OP_STI  = 4'b1011,
        OP_JMP  = 4'b1100,
        OP_RES  = 4'b1101,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } opcode_t;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_FETCH_ADDR,
        ST_FETCH_READ,
        ST_FETCH_IR,
        ST_DECODE,
        ST_ALU,
        ST_BR,
        ST_BR_TAKEN,
        ST_MEM_ADDR,
        ST_LD_READ,
        ST_LD_WRITEBACK,
        ST_ST_DATA,
        ST_ST_WRITE
    } main_state_t;

    typedef struct packed {
        logic       gate_pc;
        logic       gate_marmux;
        logic       gate_alu;
        logic       gate_mdr;
        logic       ld_pc;
        logic       ld_ir;
        logic       ld_mar;
        logic       ld_mdr;
        logic       ld_reg;
        logic       ld_cc;
        pc_sel_t    pc_sel;
        logic       sr2mux_imm;
        logic       addr1_base;
        addr2_sel_t addr2_sel;
        logic       marmux_adder;
        alu_op_t    alu_op;
        reg_idx_t   dr;
        reg_idx_t   sr1;
        reg_idx_t   sr2;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '{
        gate_pc:      1'b0,
        gate_marmux:  1'b0,
        gate_alu:     1'b0,
        gate_mdr:     1'b0,
        ld_pc:        1'b0,
        ld_ir:        1'b0,
        ld_mar:       1'b0,
        ld_mdr:       1'b0,
        ld_reg:       1'b0,
        ld_cc:        1'b0,
        pc_sel:       PC_HOLD,
        sr2mux_imm:   1'b0,
        addr1_base:   1'b0,
        addr2_sel:    2'b00,
        marmux_adder: 1'b0,
        alu_op:       2'b00,
        dr:           3'b000,
        sr1:          3'b000,
        sr2:          3'b000
    };

    // rw is 1 for a write
    typedef struct packed {
        logic req;
        logic rw;
    } mem_bus_t;

endpackage

//--- hdl/mem_handshake.sv
`timescale 1ns/1ps

module mem_handshake import lc3_ctrl_pkg::*;
(
    input  logic     i_Clk,
    input  logic     arst_n,
    input  logic     start,
    input  logic     rw,
    input  logic     mem_ack,
    output mem_bus_t mem,
    output logic     done
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_WAIT_ACK_HIGH,
        HS_WAIT_ACK_LOW
    } hs_state_t;

    hs_state_t hs_state;
    logic      rw_q;
    logic      done_q;

    always_ff @(posedge i_Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hs_state <= HS_IDLE;
            rw_q     <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (hs_state)
                HS_IDLE:
                begin
                    // direction held for the whole access
                    if (start)
                    begin
                        rw_q     <= rw;
                        hs_state <= HS_WAIT_ACK_HIGH;
                    end
                end
                HS_WAIT_ACK_HIGH:
                begin
                    if (mem_ack)
                        hs_state <= HS_WAIT_ACK_LOW;
                end
                HS_WAIT_ACK_LOW:
                begin
                    // access complete once ack is back low
                    if (!mem_ack)
                    begin
                        hs_state <= HS_IDLE;
                        done_q   <= 1'b1;
                    end
                end
                default:
                    hs_state <= HS_IDLE;
            endcase
        end
    end

    assign mem.req = (hs_state == HS_WAIT_ACK_HIGH);
    assign mem.rw  = rw_q;
    assign done    = done_q;

endmodule

//--- sequencer/micro_sequencer.sv
`timescale 1ns/1ps

module micro_sequencer import lc3_ctrl_pkg::*;
(
    input  logic        i_Clk,
    input  logic        arst_n,
    input  word_t       ir,
    input  nzp_t        nzp,
    input  logic        mem_done,
    output main_state_t state,
    output step_t       step,
    output logic        mem_start,
    output logic        mem_rw
);

    main_state_t state_nxt;
    step_t       step_nxt;
    step_t       last_step;
    opcode_t     opcode;
    logic        ben_q;
    logic        ben_nxt;
    logic        mem_wait_q;
    logic        mem_step;

    // decode target per opcode with dropped ones back to fetch
    function automatic main_state_t dispatch(input opcode_t op);
        case (op)
            OP_ADD, OP_AND, OP_NOT:
                dispatch = ST_ALU;
            OP_BR:
                dispatch = ST_BR;
            OP_LD, OP_ST:
                dispatch = ST_MEM_ADDR;
            default:
                dispatch = ST_FETCH_ADDR;
        endcase
    endfunction

    assign opcode = opcode_t'(ir[OPCODE_MSB:OPCODE_LSB]);

    // any overlap of mask and condition codes
    assign ben_nxt = |(ir[NZP_MSB:NZP_LSB] & nzp);

    // memory accesses always sit at step 0
    assign mem_step = (step == '0) &&
                      ((state == ST_FETCH_READ) ||
                       (state == ST_LD_READ) ||
                       (state == ST_ST_WRITE));

    // pulse once on entry and wait for done
    assign mem_start = mem_step && !mem_wait_q;
    assign mem_rw    = (state == ST_ST_WRITE);

    // final micro-step of each state
    always_comb
    begin
        case (state)
            ST_FETCH_ADDR, ST_ALU, ST_LD_WRITEBACK:
                last_step = 3'd2;
            ST_FETCH_READ, ST_FETCH_IR, ST_DECODE, ST_MEM_ADDR, ST_LD_READ, ST_ST_DATA:
                last_step = 3'd1;
            default:
                last_step = 3'd0;
        endcase
    end

    always_comb
    begin
        state_nxt = state;
        step_nxt  = step + 3'd1;
        if (mem_step && !mem_done)
        begin
            // stall while the access is outstanding
            step_nxt = step;
        end
        else if (step == last_step)
        begin
            step_nxt = '0;
            case (state)
                ST_RESET:
                    state_nxt = ST_FETCH_ADDR;
                ST_FETCH_ADDR:
                    state_nxt = ST_FETCH_READ;
                ST_FETCH_READ:
                    state_nxt = ST_FETCH_IR;
                ST_FETCH_IR:
                    state_nxt = ST_DECODE;
                ST_DECODE:
                    state_nxt = dispatch(opcode);
                ST_BR:
                    state_nxt = ben_q ? ST_BR_TAKEN : ST_FETCH_ADDR;
                ST_MEM_ADDR:
                    state_nxt = (opcode == OP_ST) ? ST_ST_DATA : ST_LD_READ;
                ST_LD_READ:
                    state_nxt = ST_LD_WRITEBACK;
                ST_ST_DATA:
                    state_nxt = ST_ST_WRITE;
                default:
                    state_nxt = ST_FETCH_ADDR;
            endcase
        end
    end

    always_ff @(posedge i_Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= ST_RESET;
            step       <= '0;
            ben_q      <= 1'b0;
            mem_wait_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            step  <= step_nxt;
            // ir is valid from the first decode cycle on
            if ((state == ST_DECODE) && (step == '0))
            begin
                ben_q <= ben_nxt;
            end
            if (mem_step)
            begin
                mem_wait_q <= !mem_done;
            end
        end
    end

endmodule

//--- sequencer/microcode_decode.sv
`timescale 1ns/1ps

module microcode_decode import lc3_ctrl_pkg::*;
(
    input  main_state_t state,
    input  step_t       step,
    input  word_t       ir,
    output ctrl_word_t  ctrl
);

    opcode_t  opcode;
    reg_idx_t dr_idx;
    reg_idx_t sr1_idx;
    reg_idx_t sr2_idx;
    logic     imm;
    alu_op_t  alu_op;

    assign opcode  = opcode_t'(ir[OPCODE_MSB:OPCODE_LSB]);
    assign dr_idx  = ir[DR_MSB:DR_LSB];
    assign sr1_idx = ir[SR1_MSB:SR1_LSB];
    assign sr2_idx = ir[SR2_MSB:SR2_LSB];
    assign imm     = ir[IMM_BIT];

    always_comb
    begin
        case (opcode)
            OP_ADD:
                alu_op = ALU_ADD;
            OP_AND:
                alu_op = ALU_AND;
            OP_NOT:
                alu_op = ALU_NOT;
            default:
                alu_op = ALU_PASS;
        endcase
    end

    always_comb
    begin
        ctrl = CTRL_IDLE;
        case (state)
            ST_FETCH_ADDR:
            begin
                // mar <- pc, then pc <- pc + 1
                if (step == 3'd0)
                    ctrl.gate_pc = 1'b1;
                else if (step == 3'd1)
                    ctrl.ld_mar = 1'b1;
                else if (step == 3'd2)
                begin
                    ctrl.ld_pc  = 1'b1;
                    ctrl.pc_sel = PC_INCR;
                end
            end
            ST_FETCH_READ, ST_LD_READ:
            begin
                // step 0 is the memory access itself
                if (step == 3'd1)
                    ctrl.ld_mdr = 1'b1;
            end
            ST_FETCH_IR:
            begin
                if (step == 3'd0)
                    ctrl.gate_mdr = 1'b1;
                else if (step == 3'd1)
                    ctrl.ld_ir = 1'b1;
            end
            ST_ALU:
            begin
                if (step == 3'd0)
                begin
                    ctrl.gate_alu = 1'b1;
                    ctrl.alu_op   = alu_op;
                    ctrl.sr1      = sr1_idx;
                    ctrl.sr2      = sr2_idx;
                    // not has no second operand
                    ctrl.sr2mux_imm = (opcode != OP_NOT) ? imm : 1'b0;
                end
                else if (step == 3'd1)
                begin
                    ctrl.ld_reg = 1'b1;
                    ctrl.dr     = dr_idx;
                end
                else if (step == 3'd2)
                    ctrl.ld_cc = 1'b1;
            end
            ST_BR_TAKEN:
            begin
                // pc <- pc + sext(offset9)
                ctrl.ld_pc      = 1'b1;
                ctrl.pc_sel     = PC_FROM_ADDER;
                ctrl.addr1_base = 1'b0;
                ctrl.addr2_sel  = ADDR2_OFF9;
            end
            ST_MEM_ADDR:
            begin
                if (step == 3'd0)
                begin
                    ctrl.gate_marmux  = 1'b1;
                    ctrl.marmux_adder = 1'b1;
                    ctrl.addr1_base   = 1'b0;
                    ctrl.addr2_sel    = ADDR2_OFF9;
                end
                else if (step == 3'd1)
                    ctrl.ld_mar = 1'b1;
            end
            ST_LD_WRITEBACK:
            begin
                if (step == 3'd0)
                begin
                    ctrl.gate_mdr = 1'b1;
                    ctrl.dr       = dr_idx;
                end
                else if (step == 3'd1)
                begin
                    ctrl.ld_reg = 1'b1;
                    ctrl.dr     = dr_idx;
                end
                else if (step == 3'd2)
                    ctrl.ld_cc = 1'b1;
            end
            ST_ST_DATA:
            begin
                // store source sits in the dr field
                if (step == 3'd0)
                begin
                    ctrl.gate_alu = 1'b1;
                    ctrl.alu_op   = ALU_PASS;
                    ctrl.sr2      = dr_idx;
                end
                else if (step == 3'd1)
                    ctrl.ld_mdr = 1'b1;
            end
            default:
                ctrl = CTRL_IDLE;
        endcase
    end

endmodule

//--- hdl/lc3_control_unit.sv
`timescale 1ns/1ps

module lc3_control_unit import lc3_ctrl_pkg::*;
(
    input  logic       i_Clk,
    input  logic       arst_n,
    input  word_t      ir,
    input  nzp_t       nzp,
    input  logic       mem_ack,
    output ctrl_word_t ctrl,
    output mem_bus_t   mem
);

    main_state_t state;
    step_t       step;
    logic        mem_start;
    logic        mem_rw;
    logic        mem_done;

    // state, micro-step and branch enable
    micro_sequencer i_micro_sequencer
    (
        .i_Clk     (i_Clk),
        .arst_n    (arst_n),
        .ir        (ir),
        .nzp       (nzp),
        .mem_done  (mem_done),
        .state     (state),
        .step      (step),
        .mem_start (mem_start),
        .mem_rw    (mem_rw)
    );

    // control word from state, step and ir
    microcode_decode i_microcode_decode
    (
        .state (state),
        .step  (step),
        .ir    (ir),
        .ctrl  (ctrl)
    );

    // req/ack toward memory
    mem_handshake i_mem_handshake
    (
        .i_Clk   (i_Clk),
        .arst_n  (arst_n),
        .start   (mem_start),
        .rw      (mem_rw),
        .mem_ack (mem_ack),
        .mem     (mem),
        .done    (mem_done)
    );

endmodule

//--- testbench/lc3_ctrl_assertions.sv
`timescale 1ns/1ps

module lc3_ctrl_assertions import lc3_ctrl_pkg::*;
(
    input logic     i_Clk,
    input logic     arst_n,
    input mem_bus_t mem,
    input logic     mem_ack,
    input logic     done
);

    int fail_count = 0;

    // request held until memory answers
    req_held_until_ack: assert property (@(posedge i_Clk) disable iff (!arst_n)
        (mem.req && !mem_ack) |=> mem.req)
    else
    begin
        fail_count = fail_count + 1;
        $error("req dropped before ack rose");
    end

    // a new request only after the previous ack is gone
    no_req_under_ack: assert property (@(posedge i_Clk) disable iff (!arst_n)
        $rose(mem.req) |-> !mem_ack)
    else
    begin
        fail_count = fail_count + 1;
        $error("req rose while ack was still high");
    end

    quiet_after_reset: assert property (@(posedge i_Clk)
        (!arst_n || $rose(arst_n)) |-> (!mem.req && !done))
    else
    begin
        fail_count = fail_count + 1;
        $error("req or done active in or right after reset");
    end

endmodule

bind mem_handshake lc3_ctrl_assertions i_lc3_ctrl_assertions
(
    .i_Clk   (i_Clk),
    .arst_n  (arst_n),
    .mem     (mem),
    .mem_ack (mem_ack),
    .done    (done)
);

//--- testbench/tb_lc3_control_unit.sv
`timescale 1ns/1ps

module tb_lc3_control_unit import lc3_ctrl_pkg::*; ();

    localparam int NUM_INSTR  = 300;
    localparam int CYCLE_NS   = 100;
    // about 40 cycles for the slowest instruction plus a margin
    localparam int WATCHDOG_NS = (NUM_INSTR * 40 + 100) * CYCLE_NS;

    logic       i_Clk = 1'b0;
    logic       arst_n;
    word_t      ir;
    nzp_t       nzp;
    logic       mem_ack;
    ctrl_word_t ctrl;
    mem_bus_t   mem;

    ctrl_word_t  exp_ctrl_q[$];
    mem_bus_t    exp_mem_q[$];
    logic [15:0] lfsr_q;
    logic        req_prev;
    logic        finished = 1'b0;
    int          issued = 0;
    int          ctrl_err = 0;
    int          mem_err = 0;
    int          other_err = 0;
    int          assert_err;
    int unsigned ack_delay;
    word_t       ins_nxt;
    nzp_t        cc_nxt;

    lc3_control_unit i_lc3_control_unit
    (
        .i_Clk   (i_Clk),
        .arst_n  (arst_n),
        .ir      (ir),
        .nzp     (nzp),
        .mem_ack (mem_ack),
        .ctrl    (ctrl),
        .mem     (mem)
    );

    always #50 i_Clk = ~i_Clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output int unsigned v);
        int i;
        v = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
    endtask

    function automatic opcode_t kept_opcode(input int unsigned k);
        case (k)
            0: kept_opcode = OP_ADD;
            1: kept_opcode = OP_AND;
            2: kept_opcode = OP_NOT;
            3: kept_opcode = OP_BR;
            4: kept_opcode = OP_LD;
            default: kept_opcode = OP_ST;
        endcase
    endfunction

    function automatic opcode_t dropped_opcode(input int unsigned k);
        case (k % 10)
            0: dropped_opcode = OP_JSR;
            1: dropped_opcode = OP_LDR;
            2: dropped_opcode = OP_STR;
            3: dropped_opcode = OP_RTI;
            4: dropped_opcode = OP_LDI;
            5: dropped_opcode = OP_STI;
            6: dropped_opcode = OP_JMP;
            7: dropped_opcode = OP_RES;
            8: dropped_opcode = OP_LEA;
            default: dropped_opcode = OP_TRAP;
        endcase
    endfunction

    // mostly kept opcodes with one in four dropped
    task automatic next_instr(output word_t ins, output nzp_t cc);
        opcode_t     op;
        int unsigned sel;
        int unsigned body;
        int unsigned k;
        rand_bits(3, sel);
        if (sel < 6)
            op = kept_opcode(sel);
        else
        begin
            rand_bits(4, k);
            op = dropped_opcode(k);
        end
        rand_bits(12, body);
        ins = {op, body[11:0]};
        rand_bits(2, k);
        cc = nzp_t'(3'b001 << (k % 3));
    endtask

    task automatic expect_access(input logic rw);
        mem_bus_t m;
        m.req = 1'b1;
        m.rw  = rw;
        exp_mem_q.push_back(m);
    endtask

    task automatic push_fetch();
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.gate_pc = 1'b1;
        exp_ctrl_q.push_back(w);
        w = CTRL_IDLE;
        w.ld_mar = 1'b1;
        exp_ctrl_q.push_back(w);
        w = CTRL_IDLE;
        w.ld_pc  = 1'b1;
        w.pc_sel = PC_INCR;
        exp_ctrl_q.push_back(w);
        expect_access(1'b0);
        w = CTRL_IDLE;
        w.ld_mdr = 1'b1;
        exp_ctrl_q.push_back(w);
        w = CTRL_IDLE;
        w.gate_mdr = 1'b1;
        exp_ctrl_q.push_back(w);
        w = CTRL_IDLE;
        w.ld_ir = 1'b1;
        exp_ctrl_q.push_back(w);
    endtask

    // execute words of one instruction and then the next fetch
    task automatic push_execute(input word_t ins, input nzp_t cc);
        ctrl_word_t w;
        opcode_t    op;
        op = opcode_t'(ins[15:12]);
        case (op)
            OP_ADD, OP_AND, OP_NOT:
            begin
                w = CTRL_IDLE;
                w.gate_alu   = 1'b1;
                w.alu_op     = (op == OP_ADD) ? ALU_ADD : (op == OP_AND) ? ALU_AND : ALU_NOT;
                w.sr1        = ins[8:6];
                w.sr2        = ins[2:0];
                w.sr2mux_imm = (op == OP_NOT) ? 1'b0 : ins[5];
                exp_ctrl_q.push_back(w);
                w = CTRL_IDLE;
                w.ld_reg = 1'b1;
                w.dr     = ins[11:9];
                exp_ctrl_q.push_back(w);
                w = CTRL_IDLE;
                w.ld_cc = 1'b1;
                exp_ctrl_q.push_back(w);
            end
            OP_BR:
            begin
                if (|(ins[11:9] & cc))
                begin
                    w = CTRL_IDLE;
                    w.ld_pc     = 1'b1;
                    w.pc_sel    = PC_FROM_ADDER;
                    w.addr2_sel = ADDR2_OFF9;
                    exp_ctrl_q.push_back(w);
                end
            end
            OP_LD, OP_ST:
            begin
                w = CTRL_IDLE;
                w.gate_marmux  = 1'b1;
                w.marmux_adder = 1'b1;
                w.addr2_sel    = ADDR2_OFF9;
                exp_ctrl_q.push_back(w);
                w = CTRL_IDLE;
                w.ld_mar = 1'b1;
                exp_ctrl_q.push_back(w);
                if (op == OP_LD)
                begin
                    expect_access(1'b0);
                    w = CTRL_IDLE;
                    w.ld_mdr = 1'b1;
                    exp_ctrl_q.push_back(w);
                    w = CTRL_IDLE;
                    w.gate_mdr = 1'b1;
                    w.dr       = ins[11:9];
                    exp_ctrl_q.push_back(w);
                    w.gate_mdr = 1'b0;
                    w.ld_reg   = 1'b1;
                    exp_ctrl_q.push_back(w);
                    w = CTRL_IDLE;
                    w.ld_cc = 1'b1;
                    exp_ctrl_q.push_back(w);
                end
                else
                begin
                    w = CTRL_IDLE;
                    w.gate_alu = 1'b1;
                    w.alu_op   = ALU_PASS;
                    w.sr2      = ins[11:9];
                    exp_ctrl_q.push_back(w);
                    w = CTRL_IDLE;
                    w.ld_mdr = 1'b1;
                    exp_ctrl_q.push_back(w);
                    expect_access(1'b1);
                end
            end
            default:
            begin
                // dropped opcodes fall straight through to fetch
            end
        endcase
        push_fetch();
    endtask

    task automatic compare_ctrl(input string name, input ctrl_word_t got, input ctrl_word_t exp);
        if (got !== exp)
        begin
            ctrl_err++;
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_mem(input string name, input mem_bus_t got, input mem_bus_t exp);
        if (got !== exp)
        begin
            mem_err++;
            $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // memory side of the four-phase handshake
    initial
    begin
        forever
        begin
            @(negedge i_Clk);
            if (arst_n && mem.req && !mem_ack)
            begin
                rand_bits(3, ack_delay);
                repeat (ack_delay) @(posedge i_Clk);
                @(posedge i_Clk);
                #1 mem_ack = 1'b1;
                do
                    @(negedge i_Clk);
                while (mem.req);
                @(posedge i_Clk);
                #1 mem_ack = 1'b0;
            end
        end
    end

    // checks every non-idle word and every new request mid-cycle
    initial
    begin
        req_prev = 1'b0;
        forever
        begin
            @(negedge i_Clk);
            if (!arst_n)
            begin
                if ((ctrl !== CTRL_IDLE) || (mem.req !== 1'b0))
                begin
                    other_err++;
                    $display("controller is not idle during reset at %0t ns", $time);
                end
            end
            else
            begin
                if (ctrl !== CTRL_IDLE)
                begin
                    if (mem.req || mem_ack)
                    begin
                        other_err++;
                        $display("control word active during a memory access at %0t ns", $time);
                    end
                    if (exp_ctrl_q.size() == 0)
                    begin
                        other_err++;
                        $display("control word %h at %0t ns when none was expected", ctrl, $time);
                    end
                    else
                        compare_ctrl("ctrl", ctrl, exp_ctrl_q.pop_front());
                end
                if (mem.req && !req_prev)
                begin
                    if (exp_mem_q.size() == 0)
                    begin
                        other_err++;
                        $display("memory request at %0t ns when none was expected", $time);
                    end
                    else
                        compare_mem("mem", mem, exp_mem_q.pop_front());
                end
                req_prev = mem.req;
                if (ctrl.ld_ir)
                begin
                    issued++;
                    if (issued > NUM_INSTR)
                        finished = 1'b1;
                    else
                    begin
                        // the datapath loads the next instruction into ir
                        next_instr(ins_nxt, cc_nxt);
                        push_execute(ins_nxt, cc_nxt);
                        @(posedge i_Clk);
                        #1;
                        ir  = ins_nxt;
                        nzp = cc_nxt;
                    end
                end
            end
        end
    end

    initial
    begin
        arst_n  = 1'b0;
        ir      = '0;
        nzp     = 3'b010;
        mem_ack = 1'b0;
        lfsr_q  = 16'd46;
        push_fetch();
        repeat (4) @(posedge i_Clk);
        #1 arst_n = 1'b1;
        @(negedge i_Clk);
        compare_ctrl("ctrl", ctrl, CTRL_IDLE);
        compare_mem("mem", mem, '0);
        wait (finished);
        @(negedge i_Clk);
        if ((exp_ctrl_q.size() != 0) || (exp_mem_q.size() != 0))
        begin
            other_err++;
            $display("expected control words or accesses never appeared");
        end
        assert_err = i_lc3_control_unit.i_mem_handshake.i_lc3_ctrl_assertions.fail_count;
        $display("errors: %0d ctrl, %0d mem, %0d other, %0d assertion",
                 ctrl_err, mem_err, other_err, assert_err);
        if ((ctrl_err + mem_err + other_err + assert_err) == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout, the instruction stream did not complete in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- all.f
common/lc3_ctrl_pkg.sv
hdl/mem_handshake.sv
sequencer/micro_sequencer.sv
sequencer/microcode_decode.sv
hdl/lc3_control_unit.sv
testbench/lc3_ctrl_assertions.sv
testbench/tb_lc3_control_unit.sv

//--- Bender.yml
package:
  name: lc3_control_unit

sources:
  # package first, then the design bottom up
  - common/lc3_ctrl_pkg.sv
  - hdl/mem_handshake.sv
  - sequencer/micro_sequencer.sv
  - sequencer/microcode_decode.sv
  - hdl/lc3_control_unit.sv

  # testbench and bound assertions
  - target: test
    files:
      - testbench/lc3_ctrl_assertions.sv
      - testbench/tb_lc3_control_unit.sv
